/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icache
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= tb.f

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* icache_hit_select.sv */
// second cache stage: tag compare, way and half select, miss detection
// a missing item stays here until its request is taken, squashing stage one
`timescale 1ns/1ps

module icache_hit_select import icache_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               lookup_v_i,
  input  lookup_t            lookup_i,
  input  logic               miss_req_ready_i,
  input  logic [WAY_W-1:0]   victim_way_i,

  output logic               stall_o,
  output logic               instr_v_o,
  output logic [INSTR_W-1:0] instr_o,
  output logic               hit_v_o,
  output logic [WAY_W-1:0]   hit_way_o,
  output logic [INDEX_W-1:0] hit_index_o,
  output logic               miss_v_o,
  output miss_req_t          miss_req_o,
  output logic [WAYS-1:0]    valid_o
);

  logic                 s2_v_r;
  lookup_t              s2_r;
  logic [TAG_W-1:0]     s2_tag;
  logic [WAYS-1:0]      hit_vec;
  logic                 hit_any;
  logic [WAY_W-1:0]     hit_way;
  logic [WORD_W-1:0]    hit_word;

  assign s2_tag = s2_r.addr[ADDR_W-1 -: TAG_W];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_vec[w] = s2_r.valid[w] & (s2_r.tags[w] == s2_tag);
    end
    // lowest hitting way wins
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  assign hit_any  = |hit_vec;
  assign hit_word = s2_r.data[hit_way];

  assign hit_v_o     = s2_v_r & hit_any;
  assign hit_way_o   = hit_way;
  assign hit_index_o = s2_r.addr[BLOCK_OFF_W +: INDEX_W];
  assign valid_o     = s2_r.valid;

  assign instr_v_o = hit_v_o;
  assign instr_o   = s2_r.addr[BYTE_OFF_W-1] ? hit_word[INSTR_W +: INSTR_W]
                                             : hit_word[INSTR_W-1:0];

  assign miss_v_o        = s2_v_r & ~hit_any;
  assign miss_req_o.addr = {s2_r.addr[ADDR_W-1:BLOCK_OFF_W], BLOCK_OFF_W'(0)};
  assign miss_req_o.way  = victim_way_i;

  // no new fetch while a miss sits here or the requester is busy
  assign stall_o = miss_v_o | ~miss_req_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s2_v_r <= 1'b0;
    end else if (miss_v_o) begin
      // hold until handshake, stage one item is dropped
      s2_v_r <= ~miss_req_ready_i;
    end else begin
      s2_v_r <= lookup_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!miss_v_o) begin
      s2_r <= lookup_i;
    end
  end

  // fills never leave two copies of one block in a set
  assert property (@(posedge clk_i) disable iff (reset_i)
    s2_v_r |-> $onehot0(hit_vec))
    else $error("more than one way hit");

endmodule

/* icache_lookup.sv */
// first cache stage: decodes the fetch address and reads tags, valid bits and data
// also applies fill packets, which only win a cycle with no fetch accepted
`timescale 1ns/1ps

module icache_lookup import icache_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,

  input  logic              fetch_v_i,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  output logic              fetch_ready_o,

  input  logic              fill_v_i,
  input  fill_pkt_t         fill_pkt_i,
  output logic              fill_ready_o,

  input  logic              stall_i,

  output logic              lookup_v_o,
  output lookup_t           lookup_o
);

  logic [INDEX_W-1:0]    fetch_index;
  logic [WORD_OFF_W-1:0] fetch_word_off;
  logic                  fetch_acc;
  logic                  fill_acc;
  logic                  tag_we;
  logic                  data_we;

  logic [WAYS-1:0][TAG_W-1:0] tag_mem [SETS];
  logic [WORD_W-1:0]          data_mem [WAYS][SETS*BLOCK_WORDS];
  logic [SETS-1:0][WAYS-1:0]  valid_r;

  assign fetch_index    = fetch_addr_i[BLOCK_OFF_W +: INDEX_W];
  assign fetch_word_off = fetch_addr_i[BYTE_OFF_W +: WORD_OFF_W];

  assign fetch_ready_o = ~stall_i;
  assign fetch_acc     = fetch_v_i & fetch_ready_o;

  // fetch has priority over fills
  assign fill_ready_o = ~fetch_acc;
  assign fill_acc     = fill_v_i & fill_ready_o;

  assign tag_we  = fill_acc & (fill_pkt_i.op == fill_set_tag);
  assign data_we = fill_acc & (fill_pkt_i.op == fill_write_data);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lookup_v_o <= 1'b0;
      valid_r    <= '0;
    end else begin
      lookup_v_o <= fetch_acc;
      if (fill_acc) begin
        case (fill_pkt_i.op)
          fill_set_tag:
            valid_r[fill_pkt_i.index][fill_pkt_i.way] <= fill_pkt_i.payload.tag.valid;
          fill_invalidate:
            valid_r[fill_pkt_i.index][fill_pkt_i.way] <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  // synchronous array reads and fill writes
  always_ff @(posedge clk_i) begin
    if (fetch_acc) begin
      lookup_o.addr  <= fetch_addr_i;
      lookup_o.tags  <= tag_mem[fetch_index];
      lookup_o.valid <= valid_r[fetch_index];
      for (int w = 0; w < WAYS; w++) begin
        lookup_o.data[w] <= data_mem[w][{fetch_index, fetch_word_off}];
      end
    end
    if (tag_we) begin
      tag_mem[fill_pkt_i.index][fill_pkt_i.way] <= fill_pkt_i.payload.tag.tag;
    end
    if (data_we) begin
      data_mem[fill_pkt_i.way][{fill_pkt_i.index, fill_pkt_i.payload.data.word_off}] <=
        fill_pkt_i.payload.data.data;
    end
  end

  // an undefined opcode would be dropped without touching any array
  assert property (@(posedge clk_i) disable iff (reset_i)
    fill_acc |-> (fill_pkt_i.op inside {fill_set_tag, fill_write_data, fill_invalidate}))
    else $error("fill packet with an undefined opcode");

endmodule

/* icache_lru.sv */
// tree pseudo-LRU state per set and replacement way choice
// an invalid way is always preferred over the tree's pick
`timescale 1ns/1ps

module icache_lru import icache_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               hit_v_i,
  input  logic [WAY_W-1:0]   hit_way_i,
  input  logic [INDEX_W-1:0] index_i,
  input  logic [WAYS-1:0]    valid_i,

  output logic [WAY_W-1:0]   victim_way_o
);

  // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3, 0 points low
  logic [SETS-1:0][LRU_W-1:0] lru_r;
  logic [LRU_W-1:0]           tree;
  logic                       inv_any;
  logic [WAY_W-1:0]           inv_way;
  logic [WAY_W-1:0]           lru_way;

  always_comb begin
    tree    = lru_r[index_i];
    inv_any = 1'b0;
    inv_way = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_any = 1'b1;
        inv_way = WAY_W'(w);
      end
    end
    lru_way      = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    victim_way_o = inv_any ? inv_way : lru_way;
  end

  // point the path away from the way just used
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lru_r <= '0;
    end else if (hit_v_i) begin
      lru_r[index_i][0] <= ~hit_way_i[1];
      if (hit_way_i[1]) begin
        lru_r[index_i][2] <= ~hit_way_i[0];
      end else begin
        lru_r[index_i][1] <= ~hit_way_i[0];
      end
    end
  end

endmodule

/* icache_miss_unit.sv */
// presents the miss request and tracks it until the fill is done
// busy keeps fetch stalled while the block is being refilled
`timescale 1ns/1ps

module icache_miss_unit import icache_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      miss_v_i,
  input  miss_req_t miss_req_i,
  input  logic      miss_req_ready_i,
  input  logic      fill_done_i,

  output logic      miss_req_v_o,
  output miss_req_t miss_req_o,
  output logic      miss_o,
  output logic      busy_o
);

  logic outstanding_r;
  logic handshake;

  assign miss_req_v_o = miss_v_i & ~outstanding_r;
  assign miss_req_o   = miss_req_i;
  assign handshake    = miss_req_v_o & miss_req_ready_i;
  assign miss_o       = handshake;
  assign busy_o       = outstanding_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_r <= 1'b0;
    end else if (handshake) begin
      outstanding_r <= 1'b1;
    end else if (fill_done_i) begin
      outstanding_r <= 1'b0;
    end
  end

  // fetch is held off, so stage two cannot raise a second miss
  assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_r |-> !miss_v_i)
    else $error("miss request while a miss is outstanding");

  // stage two holds its item and the set's LRU state does not move
  assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_req_v_o && !miss_req_ready_i) |=> (miss_req_v_o && $stable(miss_req_o)))
    else $error("miss request dropped or changed before handshake");

endmodule

/* icache_pkg.sv */
// widths, fill packet encoding and pipeline structs for the instruction cache
// every cache module pulls these in with a wildcard import
package icache_pkg;

  localparam int ADDR_W      = 32;
  localparam int WAYS        = 4;
  localparam int SETS        = 64;
  localparam int WORD_W      = 64;
  localparam int INSTR_W     = 32;
  localparam int BLOCK_WORDS = 4;

  // address fields, low to high: byte offset, word offset, index, tag
  localparam int BYTE_OFF_W  = $clog2(WORD_W / 8);
  localparam int WORD_OFF_W  = $clog2(BLOCK_WORDS);
  localparam int BLOCK_OFF_W = BYTE_OFF_W + WORD_OFF_W;
  localparam int INDEX_W     = $clog2(SETS);
  localparam int TAG_W       = ADDR_W - INDEX_W - BLOCK_OFF_W;
  localparam int WAY_W       = $clog2(WAYS);

  // tree pseudo-LRU, one bit per internal node
  localparam int LRU_W       = WAYS - 1;

  localparam int FILL_PAYLOAD_W = WORD_OFF_W + WORD_W;

  typedef enum logic [1:0] {
    fill_set_tag    = 2'd0,
    fill_write_data = 2'd1,
    fill_invalidate = 2'd2
  } fill_op_e;

  typedef struct packed {
    logic [FILL_PAYLOAD_W-TAG_W-2:0] spare;
    logic                            valid;
    logic [TAG_W-1:0]                tag;
  } fill_tag_t;

  typedef struct packed {
    logic [WORD_OFF_W-1:0] word_off;
    logic [WORD_W-1:0]     data;
  } fill_data_t;

  // meaning of the payload depends on the opcode
  typedef union packed {
    fill_tag_t  tag;
    fill_data_t data;
  } fill_payload_u;

  typedef struct packed {
    fill_op_e             op;
    logic [INDEX_W-1:0]   index;
    logic [WAY_W-1:0]     way;
    fill_payload_u        payload;
  } fill_pkt_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [WAY_W-1:0]  way;
  } miss_req_t;

  // stage one to stage two, data already at the requested word offset
  typedef struct packed {
    logic [ADDR_W-1:0]            addr;
    logic [WAYS-1:0][TAG_W-1:0]   tags;
    logic [WAYS-1:0]              valid;
    logic [WAYS-1:0][WORD_W-1:0]  data;
  } lookup_t;

endpackage

/* icache_top.sv */
// 4-way set-associative instruction cache, two pipeline stages
// fetch in, instruction or miss request out, refill through fill packets
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               fetch_v_i,
  input  logic [ADDR_W-1:0]  fetch_addr_i,
  output logic               fetch_ready_o,

  output logic               instr_v_o,
  output logic [INSTR_W-1:0] instr_o,
  output logic               miss_o,

  output logic               miss_req_v_o,
  output miss_req_t          miss_req_o,
  input  logic               miss_req_ready_i,
  input  logic               fill_done_i,

  input  logic               fill_v_i,
  input  fill_pkt_t          fill_pkt_i,
  output logic               fill_ready_o
);

  logic               lookup_v;
  lookup_t            lookup;
  logic               hs_stall;
  logic               miss_busy;
  logic               stall;
  logic               hit_v;
  logic [WAY_W-1:0]   hit_way;
  logic [INDEX_W-1:0] hit_index;
  logic [WAYS-1:0]    s2_valid;
  logic [WAY_W-1:0]   victim_way;
  logic               miss_v;
  miss_req_t          s2_miss_req;

  assign stall = hs_stall | miss_busy;

  icache_lookup lookup_inst (
    .clk_i, .reset_i,
    .fetch_v_i, .fetch_addr_i, .fetch_ready_o,
    .fill_v_i, .fill_pkt_i, .fill_ready_o,
    .stall_i    (stall),
    .lookup_v_o (lookup_v),
    .lookup_o   (lookup)
  );

  icache_hit_select hit_select_inst (
    .clk_i, .reset_i,
    .lookup_v_i (lookup_v),
    .lookup_i   (lookup),
    .miss_req_ready_i,
    .victim_way_i (victim_way),
    .stall_o    (hs_stall),
    .instr_v_o, .instr_o,
    .hit_v_o    (hit_v),
    .hit_way_o  (hit_way),
    .hit_index_o (hit_index),
    .miss_v_o   (miss_v),
    .miss_req_o (s2_miss_req),
    .valid_o    (s2_valid)
  );

  icache_lru lru_inst (
    .clk_i, .reset_i,
    .hit_v_i    (hit_v),
    .hit_way_i  (hit_way),
    .index_i    (hit_index),
    .valid_i    (s2_valid),
    .victim_way_o (victim_way)
  );

  icache_miss_unit miss_unit_inst (
    .clk_i, .reset_i,
    .miss_v_i   (miss_v),
    .miss_req_i (s2_miss_req),
    .miss_req_ready_i, .fill_done_i,
    .miss_req_v_o, .miss_req_o, .miss_o,
    .busy_o     (miss_busy)
  );

endmodule

/* tb.f */
icache_pkg.sv
icache_lookup.sv
icache_hit_select.sv
icache_lru.sv
icache_miss_unit.sv
icache_top.sv
tb_icache.sv

/* tb_icache.sv */
// testbench for the instruction cache, fetches checked against a reference memory
// and a model of tags, valid bits and pseudo-LRU state; assertions check each response
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

  localparam int N_TESTS    = 40;
  // cycles per access including refill and a held handshake
  localparam int TEST_BOUND = 150;
  localparam int SET_A      = 5;

  logic               clk_i;
  logic               reset_i;
  logic               fetch_v_i;
  logic [ADDR_W-1:0]  fetch_addr_i;
  logic               fetch_ready_o;
  logic               instr_v_o;
  logic [INSTR_W-1:0] instr_o;
  logic               miss_o;
  logic               miss_req_v_o;
  miss_req_t          miss_req_o;
  logic               miss_req_ready_i;
  logic               fill_done_i;
  logic               fill_v_i;
  fill_pkt_t          fill_pkt_i;
  logic               fill_ready_o;

  logic [TAG_W-1:0]   m_tag [SETS][WAYS];
  logic [WAYS-1:0]    m_valid [SETS];
  logic [LRU_W-1:0]   m_lru [SETS];
  logic [63:0]        rng;
  logic               exp_hit;
  logic [INSTR_W-1:0] exp_instr;
  miss_req_t          exp_req;
  logic               fetch_acc;

  icache_top icache_top_inst (.*);

  assign fetch_acc = fetch_v_i & fetch_ready_o;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // reference memory, one 64-bit word per word address
  function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    return xorshift(64'(addr[ADDR_W-1:BYTE_OFF_W]));
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag, input int set,
                                                  input logic [2:0] sub);
    return {tag, INDEX_W'(set), sub, 2'b00};
  endfunction

  function automatic logic [WAY_W-1:0] pick_victim(input int s);
    logic [LRU_W-1:0] t;
    t = m_lru[s];
    for (int w = 0; w < WAYS; w++) begin
      if (!m_valid[s][w]) return WAY_W'(w);
    end
    // root picks the half, then that half's child picks the way
    if (t[0]) return t[2] ? WAY_W'(3) : WAY_W'(2);
    return t[1] ? WAY_W'(1) : WAY_W'(0);
  endfunction

  task automatic touch_lru(input int s, input logic [WAY_W-1:0] w);
    m_lru[s][0] = (w < 2);
    if (w < 2)
      m_lru[s][1] = (w == 0);
    else
      m_lru[s][2] = (w == 2);
  endtask

  // resolution comes two edges after acceptance
  assert property (@(posedge clk_i) disable iff (reset_i)
    ($past(fetch_acc, 2) && exp_hit) |-> (instr_v_o && instr_o == exp_instr && !miss_o))
    else report_fail($sformatf("FAIL %0t instr_o got %b/%h expected 1/%h", $time,
      $sampled(instr_v_o), $sampled(instr_o), $sampled(exp_instr)));
  assert property (@(posedge clk_i) disable iff (reset_i)
    ($past(fetch_acc, 2) && !exp_hit) |-> (miss_req_v_o && !instr_v_o))
    else report_fail($sformatf("FAIL %0t miss_req_v_o got %b expected 1", $time,
      $sampled(miss_req_v_o)));
  assert property (@(posedge clk_i) disable iff (reset_i)
    instr_v_o |-> ($past(fetch_acc, 2) && exp_hit))
    else report_fail($sformatf("FAIL %0t instr_v_o got 1 expected 0", $time));
  assert property (@(posedge clk_i) disable iff (reset_i)
    miss_req_v_o |-> (miss_req_o == exp_req))
    else report_fail($sformatf("FAIL %0t miss_req_o got %h/%0d expected %h/%0d", $time,
      $sampled(miss_req_o.addr), $sampled(miss_req_o.way), $sampled(exp_req.addr),
      $sampled(exp_req.way)));
  assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_req_v_o && !miss_req_ready_i) |=> (miss_req_v_o && $stable(miss_req_o)))
    else report_fail("miss request dropped or changed before its handshake");
  assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_req_v_o && !miss_req_ready_i) |-> (!fetch_ready_o && !instr_v_o && !miss_o))
    else report_fail("fetch ready, instruction or miss pulse while the request waits");
  assert property (@(posedge clk_i) disable iff (reset_i)
    miss_o |-> (!exp_hit && miss_req_v_o && miss_req_ready_i))
    else report_fail("miss pulse without a miss request handshake");
  assert property (@(posedge clk_i) disable iff (reset_i)
    miss_o |=> !miss_o)
    else report_fail("miss pulse longer than one cycle");
  assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_acc |-> !fill_ready_o)
    else report_fail($sformatf("FAIL %0t fill_ready_o got %b expected 0", $time,
      $sampled(fill_ready_o)));

  task automatic fetch(input logic [ADDR_W-1:0] addr, input logic hit, input miss_req_t req,
                       input bit stall_req);
    logic [WORD_W-1:0] word;
    word = mem_word(addr);
    @(posedge clk_i);
    fetch_v_i    <= 1'b1;
    fetch_addr_i <= addr;
    exp_hit      <= hit;
    exp_req      <= req;
    exp_instr    <= addr[2] ? word[63:32] : word[31:0];
    @(negedge clk_i);
    while (!fetch_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    fetch_v_i <= 1'b0;
    if (stall_req) miss_req_ready_i <= 1'b0;
  endtask

  task automatic wait_result(input int hold);
    @(negedge clk_i);
    while (!instr_v_o && !miss_req_v_o) @(negedge clk_i);
    if (miss_req_v_o) begin
      if (hold > 0) begin
        repeat (hold) @(posedge clk_i);
        miss_req_ready_i <= 1'b1;
        @(negedge clk_i);
      end
      while (!miss_o) @(negedge clk_i);
    end
  endtask

  task automatic send_fill(input fill_pkt_t pkt);
    @(posedge clk_i);
    fill_v_i   <= 1'b1;
    fill_pkt_i <= pkt;
    @(negedge clk_i);
    while (!fill_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    fill_v_i <= 1'b0;
  endtask

  // tag first, then the four words, then done
  task automatic refill(input logic [ADDR_W-1:0] addr, input logic [WAY_W-1:0] way);
    fill_pkt_t pkt;
    int        s;
    s     = int'(addr[BLOCK_OFF_W +: INDEX_W]);
    pkt   = '0;
    pkt.op    = fill_set_tag;
    pkt.index = addr[BLOCK_OFF_W +: INDEX_W];
    pkt.way   = way;
    pkt.payload.tag.valid = 1'b1;
    pkt.payload.tag.tag   = addr[ADDR_W-1 -: TAG_W];
    send_fill(pkt);
    pkt.op = fill_write_data;
    for (int w = 0; w < BLOCK_WORDS; w++) begin
      pkt.payload.data.word_off = WORD_OFF_W'(w);
      pkt.payload.data.data = mem_word({addr[ADDR_W-1:BLOCK_OFF_W], WORD_OFF_W'(w), 3'b000});
      send_fill(pkt);
    end
    @(posedge clk_i);
    fill_done_i <= 1'b1;
    @(posedge clk_i);
    fill_done_i <= 1'b0;
    m_tag[s][way]   = addr[ADDR_W-1 -: TAG_W];
    m_valid[s][way] = 1'b1;
  endtask

  // one fetch to a hit, refilling first when the model says miss
  task automatic access(input logic [ADDR_W-1:0] addr, input int hold);
    int               s;
    logic             hit;
    logic [WAY_W-1:0] way;
    miss_req_t        req;
    s   = int'(addr[BLOCK_OFF_W +: INDEX_W]);
    hit = 1'b0;
    way = '0;
    req = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (!hit && m_valid[s][w] && m_tag[s][w] == addr[ADDR_W-1 -: TAG_W]) begin
        hit = 1'b1;
        way = WAY_W'(w);
      end
    end
    if (!hit) begin
      way      = pick_victim(s);
      // a block is 32 bytes
      req.addr = addr & ~ADDR_W'(BLOCK_WORDS * WORD_W / 8 - 1);
      req.way  = way;
      fetch(addr, 1'b0, req, hold > 0);
      wait_result(hold);
      refill(addr, way);
    end
    fetch(addr, 1'b1, req, 1'b0);
    wait_result(0);
    touch_lru(s, way);
  endtask

  initial begin
    fill_pkt_t        pkt;
    logic [TAG_W-1:0] tag;
    logic [WAY_W-1:0] way;
    reset_i          <= 1'b1;
    fetch_v_i        <= 1'b0;
    fetch_addr_i     <= '0;
    miss_req_ready_i <= 1'b1;
    fill_done_i      <= 1'b0;
    fill_v_i         <= 1'b0;
    fill_pkt_i       <= '0;
    exp_hit          <= 1'b0;
    exp_instr        <= '0;
    exp_req          <= '0;
    for (int s = 0; s < SETS; s++) begin
      m_valid[s] = '0;
      m_lru[s]   = '0;
    end
    rng = 64'd77;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;

    rng = xorshift(rng);
    access({rng[31:2], 2'b00}, 0);

    // empty set fills ways in order
    for (int t = 0; t < WAYS; t++) begin
      rng = xorshift(rng);
      access(make_addr(TAG_W'(t + 1), SET_A, rng[2:0]), 0);
    end

    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 6; i++) begin
        rng = xorshift(rng);
        access(make_addr(m_tag[SET_A][rng[4:3]], SET_A, rng[2:0]), 0);
      end
      access(make_addr(TAG_W'(16 + r), SET_A, 3'd0), 0);
    end

    rng       = xorshift(rng);
    way       = rng[1:0];
    tag       = m_tag[SET_A][way];
    pkt       = '0;
    pkt.op    = fill_invalidate;
    pkt.index = INDEX_W'(SET_A);
    pkt.way   = way;
    send_fill(pkt);
    m_valid[SET_A][way] = 1'b0;
    access(make_addr(tag, SET_A, 3'd5), 0);

    access(make_addr(TAG_W'(7), SET_A + 1, 3'd2), 8);

    // small pool of tags and sets so evictions and hits mix
    for (int i = 0; i < 12; i++) begin
      rng = xorshift(rng);
      access(make_addr(TAG_W'(rng[10:8]), int'(rng[13:12]) + 8, rng[2:0]),
             (i % 4 == 3) ? 3 : 0);
    end

    $display(">>> PASS");
    $finish;
  end

  initial begin
    #(N_TESTS * TEST_BOUND * 10 + 200);
    report_fail("timeout, the cache stopped answering fetches or fills");
  end

endmodule
